// ==== hw/dbg_apb_regs.sv ====
// APB slave with the debug predictor configuration registers
// Zero wait states, unmapped offsets answer with pslverr
// Halt address and mtvec are word aligned on write
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module dbg_apb_regs (
  input  logic                   cov_assert_if,
  input  logic                   reset_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`DBG_APB_AW-1:0] paddr_i,
  input  dbg_pkg::xlen_t         pwdata_i,
  output dbg_pkg::xlen_t         prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  output dbg_pkg::dbg_cfg_t      cfg_o
);
  import dbg_pkg::*;

  logic  access;
  logic  wr_en;
  logic  mapped;
  xlen_t ctrl_word;

  // ------------------------------------------------------------------------
  // Access decode
  // ------------------------------------------------------------------------
  assign access   = psel_i && penable_i;
  assign wr_en    = access && pwrite_i;
  assign pready_o = 1'b1;

  always_comb begin
    ctrl_word                    = '0;
    ctrl_word[`DBG_CTRL_STEP]    = cfg_o.step;
    ctrl_word[`DBG_CTRL_EBREAKM] = cfg_o.ebreakm;
    ctrl_word[`DBG_CTRL_TRIG_EN] = cfg_o.trig_en;
  end

  // Read mux, also tells whether the offset is mapped
  always_comb begin
    mapped = 1'b1;
    case (paddr_i)
      `DBG_REG_CTRL:   prdata_o = ctrl_word;
      `DBG_REG_TDATA2: prdata_o = cfg_o.tdata2;
      `DBG_REG_HALT:   prdata_o = cfg_o.halt_addr;
      `DBG_REG_MTVEC:  prdata_o = cfg_o.mtvec;
      default: begin
        prdata_o = '0;
        mapped   = 1'b0;
      end
    endcase
  end

  assign pslverr_o = access && !mapped;

  // ------------------------------------------------------------------------
  // Register writes
  // ------------------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      cfg_o <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        `DBG_REG_CTRL: begin
          cfg_o.step    <= pwdata_i[`DBG_CTRL_STEP];
          cfg_o.ebreakm <= pwdata_i[`DBG_CTRL_EBREAKM];
          cfg_o.trig_en <= pwdata_i[`DBG_CTRL_TRIG_EN];
        end
        `DBG_REG_TDATA2: cfg_o.tdata2 <= pwdata_i;
        // Low two bits dropped, the core only jumps to word addresses
        `DBG_REG_HALT:   cfg_o.halt_addr <= {pwdata_i[`DBG_XLEN-1:2], 2'b00};
        `DBG_REG_MTVEC:  cfg_o.mtvec <= {pwdata_i[`DBG_XLEN-1:2], 2'b00};
        default: begin
          cfg_o <= cfg_o;
        end
      endcase
    end
  end

endmodule

// ==== hw/dbg_pkg.sv ====
// Shared types of the debug response predictor
// Retire records, decoded records, configuration and the response record
`include "dbg_cfg.svh"

package dbg_pkg;

  // Address and instruction word
  typedef logic [`DBG_XLEN-1:0] xlen_t;

  // Debug cause, encoded as in dcsr
  typedef logic [2:0] cause_t;

  typedef enum logic [1:0] {
    OTHER,
    EBREAK,
    WFI,
    DRET
  } insn_class_t;

  typedef enum logic [2:0] {
    ACT_NONE,
    ACT_ENTER_DEBUG,
    ACT_EXCEPTION,
    ACT_RELAUNCH,
    ACT_EXIT_DEBUG,
    ACT_ILLEGAL
  } action_t;

  // Software configuration, address fields already word aligned
  typedef struct packed {
    logic  step;
    logic  ebreakm;
    logic  trig_en;
    xlen_t tdata2;
    xlen_t halt_addr;
    xlen_t mtvec;
  } dbg_cfg_t;

  // Raw retirement record from the core
  typedef struct packed {
    logic  valid;
    xlen_t pc;
    xlen_t next_pc;
    xlen_t insn;
    logic  err;
    logic  debug_mode;
  } retire_t;

  typedef struct packed {
    logic        valid;
    xlen_t       pc;
    xlen_t       next_pc;
    insn_class_t cls;
    logic        debug_mode;
    logic        dbg_req;
  } dec_rec_t;

  // Predicted control-flow response for one retired instruction
  typedef struct packed {
    action_t action;
    cause_t  cause;
    xlen_t   target;
    xlen_t   dpc;
    logic    in_wfi;
  } dbg_status_t;

endpackage

// ==== hw/debug_cause_tracker.sv ====
// Debug cause tracker
// Decides the response for each retired instruction in priority order
// trigger, ebreak, halt request, step. Tracks the pending request,
// WFI sleep and the last predicted dpc for dret
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module debug_cause_tracker (
  input  logic                  cov_assert_if,
  input  logic                  reset_i,
  input  dbg_pkg::dec_rec_t     rec_i,
  input  dbg_pkg::dbg_cfg_t     cfg_i,
  output logic                  stat_valid_o,
  output dbg_pkg::dbg_status_t  stat_o
);
  import dbg_pkg::*;

  logic        pend_q;
  logic        in_wfi_q;
  xlen_t       last_dpc_q;
  logic        req_seen;
  logic        trig_hit;
  logic        pend_d;
  logic        in_wfi_d;
  dbg_status_t stat_d;

  // A request arriving with the record already counts for it
  assign req_seen = pend_q || rec_i.dbg_req;
  assign trig_hit = cfg_i.trig_en && (rec_i.pc == cfg_i.tdata2);

  // ------------------------------------------------------------------------
  // Response decision
  // ------------------------------------------------------------------------
  always_comb begin
    stat_d = '0;
    if (rec_i.valid && !rec_i.debug_mode) begin
      if (trig_hit) begin
        stat_d.action = ACT_ENTER_DEBUG;
        stat_d.cause  = `DBG_CAUSE_TRIGGER;
        stat_d.target = cfg_i.halt_addr;
        stat_d.dpc    = rec_i.pc;
      end else if ((rec_i.cls == EBREAK) && cfg_i.ebreakm) begin
        stat_d.action = ACT_ENTER_DEBUG;
        stat_d.cause  = `DBG_CAUSE_EBREAK;
        stat_d.target = cfg_i.halt_addr;
        stat_d.dpc    = rec_i.pc;
      end else if (rec_i.cls == EBREAK) begin
        // Breakpoint exception, dpc field carries mepc
        stat_d.action = ACT_EXCEPTION;
        stat_d.cause  = `DBG_CAUSE_NONE;
        stat_d.target = cfg_i.mtvec;
        stat_d.dpc    = rec_i.pc;
      end else if (rec_i.cls == DRET) begin
        stat_d.action = ACT_ILLEGAL;
        stat_d.target = cfg_i.mtvec;
      end else if (req_seen) begin
        stat_d.action = ACT_ENTER_DEBUG;
        stat_d.cause  = `DBG_CAUSE_HALTREQ;
        stat_d.target = cfg_i.halt_addr;
        stat_d.dpc    = rec_i.next_pc;
      end else if (cfg_i.step) begin
        stat_d.action = ACT_ENTER_DEBUG;
        stat_d.cause  = `DBG_CAUSE_STEP;
        stat_d.target = cfg_i.halt_addr;
        stat_d.dpc    = rec_i.next_pc;
      end
    end else if (rec_i.valid) begin
      // Already in debug mode
      if (rec_i.cls == EBREAK) begin
        stat_d.action = ACT_RELAUNCH;
        stat_d.target = cfg_i.halt_addr;
      end else if (rec_i.cls == DRET) begin
        stat_d.action = ACT_EXIT_DEBUG;
        stat_d.target = last_dpc_q;
      end
    end

    // Pending request only goes away once it is reported
    pend_d = req_seen && (stat_d.cause != `DBG_CAUSE_HALTREQ);

    // ACT_NONE already implies step clear and no request outstanding
    in_wfi_d = in_wfi_q;
    if (rec_i.valid && !rec_i.debug_mode && (rec_i.cls == WFI) &&
        (stat_d.action == ACT_NONE)) begin
      in_wfi_d = 1'b1;
    end
    if (rec_i.dbg_req) begin
      in_wfi_d = 1'b0;
    end
    stat_d.in_wfi = in_wfi_d;
  end

  // ------------------------------------------------------------------------
  // State and status registers
  // ------------------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (rec_i.valid) begin
      stat_o <= stat_d;
    end
    if (reset_i) begin
      stat_valid_o <= 1'b0;
      pend_q       <= 1'b0;
      in_wfi_q     <= 1'b0;
      last_dpc_q   <= '0;
    end else begin
      stat_valid_o <= rec_i.valid;
      pend_q       <= pend_d;
      in_wfi_q     <= in_wfi_d;
      // dret returns to the pc saved at the last debug entry
      if (stat_d.action == ACT_ENTER_DEBUG) begin
        last_dpc_q <= stat_d.dpc;
      end
    end
  end

endmodule

// ==== hw/debug_predictor_top.sv ====
// Debug response predictor top level
// APB configuration, retire decode, cause tracking and output register
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module debug_predictor_top (
  input  logic                   cov_assert_if,
  input  logic                   reset_i,
  // APB configuration port
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`DBG_APB_AW-1:0] paddr_i,
  input  dbg_pkg::xlen_t         pwdata_i,
  output dbg_pkg::xlen_t         prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // Core retirement stream
  input  dbg_pkg::retire_t       retire_i,
  input  logic                   debug_req_i,
  // Predicted response
  output logic                   status_valid_o,
  output dbg_pkg::dbg_status_t   status_o
);
  import dbg_pkg::*;

  dbg_cfg_t    cfg;
  dec_rec_t    rec;
  logic        stat_valid;
  dbg_status_t stat;

  dbg_apb_regs u_dbg_apb_regs (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .cfg_o         (cfg)
  );

  retire_decoder u_retire_decoder (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .retire_i      (retire_i),
    .debug_req_i   (debug_req_i),
    .rec_o         (rec)
  );

  debug_cause_tracker u_debug_cause_tracker (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .rec_i         (rec),
    .cfg_i         (cfg),
    .stat_valid_o  (stat_valid),
    .stat_o        (stat)
  );

  debug_response_out u_debug_response_out (
    .cov_assert_if  (cov_assert_if),
    .reset_i        (reset_i),
    .stat_valid_i   (stat_valid),
    .stat_i         (stat),
    .status_valid_o (status_valid_o),
    .status_o       (status_o)
  );

endmodule

// ==== hw/debug_response_out.sv ====
// Response output stage
// Registers the predicted response once more and keeps the record
// stable between valid pulses
`timescale 1ns/10ps

module debug_response_out (
  input  logic                 cov_assert_if,
  input  logic                 reset_i,
  input  logic                 stat_valid_i,
  input  dbg_pkg::dbg_status_t stat_i,
  output logic                 status_valid_o,
  output dbg_pkg::dbg_status_t status_o
);

  // ------------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    // Record only changes with a new response
    if (stat_valid_i) begin
      status_o <= stat_i;
    end
    if (reset_i) begin
      status_valid_o <= 1'b0;
    end else begin
      // One pulse per record, no back-pressure
      status_valid_o <= stat_valid_i;
    end
  end

endmodule

// ==== hw/retire_decoder.sv ====
// Retire stage decoder
// Classifies each retired instruction as ebreak, wfi, dret or other
// and registers it with the pc fields and the debug request sample
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module retire_decoder (
  input  logic              cov_assert_if,
  input  logic              reset_i,
  input  dbg_pkg::retire_t  retire_i,
  input  logic              debug_req_i,
  output dbg_pkg::dec_rec_t rec_o
);
  import dbg_pkg::*;

  logic        is_ebreak;
  logic        is_cebreak;
  insn_class_t cls;

  // ------------------------------------------------------------------------
  // Classification
  // ------------------------------------------------------------------------
  assign is_ebreak  = (retire_i.insn == `DBG_INSN_EBREAK);
  // Compressed form only looks at the low halfword
  assign is_cebreak = ((retire_i.insn & 32'h0000_FFFF) == `DBG_INSN_CEBREAK);

  always_comb begin
    cls = OTHER;
    if (retire_i.err) begin
      // Faulting instructions never count as ebreak, wfi or dret
      cls = OTHER;
    end else if (is_ebreak || is_cebreak) begin
      cls = EBREAK;
    end else if (retire_i.insn == `DBG_INSN_WFI) begin
      cls = WFI;
    end else if (retire_i.insn == `DBG_INSN_DRET) begin
      cls = DRET;
    end
  end

  // ------------------------------------------------------------------------
  // Record register
  // ------------------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    rec_o.pc         <= retire_i.pc;
    rec_o.next_pc    <= retire_i.next_pc;
    rec_o.cls        <= cls;
    rec_o.debug_mode <= retire_i.debug_mode;
    if (reset_i) begin
      rec_o.valid   <= 1'b0;
      rec_o.dbg_req <= 1'b0;
    end else begin
      rec_o.valid   <= retire_i.valid;
      // Request is sampled every cycle, with or without a record
      rec_o.dbg_req <= debug_req_i;
    end
  end

endmodule

// ==== include/dbg_cfg.svh ====
// Debug response predictor configuration
// Data widths, instruction encodings, APB register map and debug cause codes
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Data and bus widths
`define DBG_XLEN   32
`define DBG_APB_AW 4

// Instruction encodings, c.ebreak sits in the low halfword
`define DBG_INSN_EBREAK  32'h0010_0073
`define DBG_INSN_CEBREAK 32'h0000_9002
`define DBG_INSN_WFI     32'h1050_0073
`define DBG_INSN_DRET    32'h7B20_0073

// APB register offsets
`define DBG_REG_CTRL   4'h0
`define DBG_REG_TDATA2 4'h4
`define DBG_REG_HALT   4'h8
`define DBG_REG_MTVEC  4'hC

// Bit positions in the control register
`define DBG_CTRL_STEP    0
`define DBG_CTRL_EBREAKM 1
`define DBG_CTRL_TRIG_EN 2

// Debug cause codes as seen in dcsr.cause
`define DBG_CAUSE_NONE    3'd0
`define DBG_CAUSE_EBREAK  3'd1
`define DBG_CAUSE_TRIGGER 3'd2
`define DBG_CAUSE_HALTREQ 3'd3
`define DBG_CAUSE_STEP    3'd4

`endif

// ==== project.f ====
+incdir+include
hw/dbg_pkg.sv
hw/dbg_apb_regs.sv
hw/retire_decoder.sv
hw/debug_cause_tracker.sv
hw/debug_response_out.sv
hw/debug_predictor_top.sv
sim/tb_debug_predictor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the debug predictor testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f project.f --top-module tb_debug_predictor -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_debug_predictor)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== sim/debug_vectors.txt ====
// kind 0 APB write: 0 offset data, kind 1 APB read: 1 offset data pslverr
// kind 2 retire: 2 flags pc next_pc insn resp target dpc, kind F ends the list
// flags bit0 err, bit1 debug_mode, bit2 debug_req
// resp bits 2:0 action, bits 6:4 cause, bit 8 in_wfi
// Reset values, register map and alignment
1 0 00000000 0 0 0 0 0
1 4 00000000 0 0 0 0 0
0 8 00000803 0 0 0 0 0
0 C 00001002 0 0 0 0 0
0 4 00000200 0 0 0 0 0
0 0 FFFFFFF2 0 0 0 0 0
1 8 00000800 0 0 0 0 0
1 C 00001000 0 0 0 0 0
1 4 00000200 0 0 0 0 0
1 0 00000002 0 0 0 0 0
1 2 00000000 1 0 0 0 0
1 D 00000000 1 0 0 0 0
// ebreakm set, entry with cause 1, relaunch and exit in debug mode
2 0 00000100 00000104 00100073 011 00000800 00000100
2 0 00000110 00000112 ABCD9002 011 00000800 00000110
2 2 00000800 00000804 00100073 003 00000800 00000000
2 2 00000804 00000808 00000013 000 00000000 00000000
2 2 00000808 0000080C 7B200073 004 00000110 00000000
2 1 00000120 00000124 00100073 000 00000000 00000000
// ebreakm clear, breakpoint exception and illegal dret
0 0 00000000 0 0 0 0 0
2 0 00000130 00000134 00100073 002 00001000 00000130
2 0 00000140 00000144 7B200073 005 00001000 00000000
2 0 00000150 00000152 00009002 002 00001000 00000150
// Trigger beats a request, the request follows on the next record
0 0 00000004 0 0 0 0 0
2 4 00000200 00000204 00000013 021 00000800 00000200
2 0 00000204 00000208 00000013 031 00000800 00000208
2 0 00000208 0000020C 00000013 000 00000000 00000000
2 2 00000900 00000904 7B200073 004 00000208 00000000
// Single step, a WFI under step does not sleep
0 0 00000001 0 0 0 0 0
2 0 00000300 00000304 00000013 041 00000800 00000304
2 0 00000310 00000314 10500073 041 00000800 00000314
0 0 00000000 0 0 0 0 0
// WFI sleep and wake-up by a debug request
2 0 00000400 00000404 10500073 100 00000000 00000000
2 0 00000404 00000408 00000013 100 00000000 00000000
2 4 00000408 0000040C 00000013 031 00000800 0000040C
2 2 00000800 00000804 7B200073 004 0000040C 00000000
2 1 00000410 00000414 10500073 000 00000000 00000000
1 0 00000000 0 0 0 0 0
F 0 00000000 0 0 0 0 0

// ==== sim/tb_debug_predictor.sv ====
// Testbench for the debug response predictor
// Replays APB configuration accesses and retire records from a vectors
// file and checks every predicted response in order
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module tb_debug_predictor;
  import dbg_pkg::*;

  localparam int MAX_VECS = 64;
  localparam int WORDS    = 8;

  // Expected response tagged with its vector line
  typedef struct packed {
    logic [15:0] vec_idx;
    dbg_status_t status;
  } expect_t;

  logic                   cov_assert_if = 1'b0;
  logic                   reset_i;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  logic [`DBG_APB_AW-1:0] paddr_i;
  xlen_t                  pwdata_i;
  xlen_t                  prdata_o;
  logic                   pready_o;
  logic                   pslverr_o;
  retire_t                retire_i;
  logic                   debug_req_i;
  logic                   status_valid_o;
  dbg_status_t            status_o;

  logic [31:0] vec_mem [0:MAX_VECS*WORDS-1];
  int          n_vec;
  logic [31:0] lcg_state;
  expect_t     exp_q [$];

  debug_predictor_top u_debug_predictor_top (
    .cov_assert_if  (cov_assert_if),
    .reset_i        (reset_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .retire_i       (retire_i),
    .debug_req_i    (debug_req_i),
    .status_valid_o (status_valid_o),
    .status_o       (status_o)
  );

  always #10 cov_assert_if = ~cov_assert_if;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] vec_word(input int idx, input int k);
    return vec_mem[idx*WORDS + k];
  endfunction

  // LCG step, bits 17:16 give 0 to 3 idle cycles
  function automatic logic [1:0] idle_cycles();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16];
  endfunction

  function automatic int count_vectors();
    int n;
    n = 0;
    while (n < MAX_VECS && vec_word(n, 0) != 32'hF) begin
      n++;
    end
    return n;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic write_reg(input int idx);
    logic [31:0] addr_w;
    addr_w = vec_word(idx, 1);
    @(posedge cov_assert_if);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr_w[`DBG_APB_AW-1:0];
    pwdata_i  <= vec_word(idx, 2);
    @(posedge cov_assert_if);
    penable_i <= 1'b1;
    @(posedge cov_assert_if);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  // Read data and pslverr are checked in the middle of the access phase
  task automatic check_reg_read(input int idx);
    logic [31:0] addr_w;
    xlen_t       want_data;
    logic [31:0] want_err;
    addr_w    = vec_word(idx, 1);
    want_data = vec_word(idx, 2);
    want_err  = vec_word(idx, 3);
    @(posedge cov_assert_if);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr_w[`DBG_APB_AW-1:0];
    @(posedge cov_assert_if);
    penable_i <= 1'b1;
    @(negedge cov_assert_if);
    assert (prdata_o == want_data && pslverr_o == want_err[0] && pready_o) else begin
      stop_with_error($sformatf(
        {"mismatch at %0t ns: vector %0d read offset %h gave %h pslverr %0b,",
         " expected %h pslverr %0b"},
        $time, idx, addr_w[`DBG_APB_AW-1:0], prdata_o, pslverr_o, want_data, want_err[0]));
    end
    @(posedge cov_assert_if);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic drive_retire(input int idx);
    retire_t     rec;
    expect_t     want;
    logic [31:0] flags;
    logic [31:0] resp;
    logic [1:0]  idle;
    flags              = vec_word(idx, 1);
    resp               = vec_word(idx, 5);
    rec.valid          = 1'b1;
    rec.pc             = vec_word(idx, 2);
    rec.next_pc        = vec_word(idx, 3);
    rec.insn           = vec_word(idx, 4);
    rec.err            = flags[0];
    rec.debug_mode     = flags[1];
    want.vec_idx       = 16'(idx);
    want.status.action = action_t'(resp[2:0]);
    want.status.cause  = resp[6:4];
    want.status.target = vec_word(idx, 6);
    want.status.dpc    = vec_word(idx, 7);
    want.status.in_wfi = resp[8];
    idle = idle_cycles();
    @(posedge cov_assert_if);
    retire_i    <= rec;
    debug_req_i <= flags[2];
    exp_q.push_back(want);
    repeat (idle) begin
      @(posedge cov_assert_if);
      retire_i.valid <= 1'b0;
      debug_req_i    <= 1'b0;
    end
  endtask

  // Idle the retire port and give the pipeline time to empty
  task automatic drain_pipeline();
    int n;
    @(posedge cov_assert_if);
    retire_i.valid <= 1'b0;
    debug_req_i    <= 1'b0;
    n = 0;
    while (n < 8 && exp_q.size() != 0) begin
      @(posedge cov_assert_if);
      n++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Scoreboard, responses compared in order
  // --------------------------------------------------------------------------
  always @(negedge cov_assert_if) begin : scoreboard
    expect_t want;
    if (!reset_i && status_valid_o) begin
      assert (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        assert (status_o == want.status) else begin
          stop_with_error($sformatf(
            {"mismatch at %0t ns: vector %0d got action %0d cause %0d target %h dpc %h",
             " in_wfi %0b, expected action %0d cause %0d target %h dpc %h in_wfi %0b"},
            $time, want.vec_idx, status_o.action, status_o.cause, status_o.target,
            status_o.dpc, status_o.in_wfi, want.status.action, want.status.cause,
            want.status.target, want.status.dpc, want.status.in_wfi));
        end
      end else begin
        stop_with_error($sformatf("status pulse at %0t ns with no record pending", $time));
      end
    end
  end

  initial begin : watchdog
    @(posedge cov_assert_if);
    repeat (n_vec * 8 + 50) @(posedge cov_assert_if);
    stop_with_error($sformatf("the run did not finish within %0d cycles", n_vec * 8 + 50));
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin : main_flow
    logic [31:0] kind;
    $timeformat(-9, 0, "", 0);
    reset_i     = 1'b1;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    retire_i    = '0;
    debug_req_i = 1'b0;
    lcg_state   = 32'd46;
    $readmemh("sim/debug_vectors.txt", vec_mem);
    n_vec = count_vectors();
    assert (n_vec > 0 && vec_word(n_vec, 0) == 32'hF) else begin
      stop_with_error("the vector file is missing, empty or has no end marker");
    end

    repeat (2) @(posedge cov_assert_if);
    reset_i <= 1'b0;
    @(negedge cov_assert_if);
    assert (!status_valid_o && !pslverr_o) else begin
      stop_with_error("status_valid_o or pslverr_o is high right after reset");
    end

    for (int vi = 0; vi < n_vec; vi++) begin
      kind = vec_word(vi, 0);
      case (kind)
        32'h0, 32'h1: begin
          // Configuration only changes with an empty pipeline
          drain_pipeline();
          assert (exp_q.size() == 0) else begin
            stop_with_error("records still in flight before an APB access");
          end
          if (kind == 32'h0) begin
            write_reg(vi);
          end else begin
            check_reg_read(vi);
          end
        end
        32'h2: drive_retire(vi);
        default: stop_with_error($sformatf("vector %0d has an unknown kind %h", vi, kind));
      endcase
    end

    drain_pipeline();
    if (exp_q.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_with_error($sformatf("%0d expected responses never arrived", exp_q.size()));
    end
  end

endmodule
